//--- lsu_mem.f
verilog/lsu_mem_pkg.sv
verilog/word_ram.sv
verilog/mem_arbiter.sv
verilog/daccess_ctrl.sv
verilog/ifetch_ctrl.sv
verilog/lsu_mem_top.sv
dv/lsu_mem_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' lsu_mem.f)

obj_dir/Vlsu_mem_tb: lsu_mem.f $(SRCS)
	verilator --binary --timing --assert -f lsu_mem.f --top-module lsu_mem_tb

run: obj_dir/Vlsu_mem_tb
	./obj_dir/Vlsu_mem_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- dv/lsu_mem_tb.sv
`timescale 1ns/100ps

module lsu_mem_tb import lsu_mem_pkg::*; ();

    localparam int MEM_BYTES   = MEM_WORDS * 4;
    localparam int N_INIT      = 96;   // words 0..95 written first
    localparam int N_LOAD_BASE = 8;
    localparam int N_STORE     = 40;
    localparam int N_FETCH     = 32;
    localparam int N_STRESS    = 60;   // per port
    localparam int TOTAL_OPS   = 2 * N_INIT + 12 * N_LOAD_BASE + 3 * N_STORE + N_FETCH
                                 + 2 * N_STRESS;
    localparam int TIMEOUT     = 20 * TOTAL_OPS;
    // four word accesses, each possibly queued behind one access of the other port
    localparam int RR_WINDOW   = 20;
    localparam logic [31:0] SEED = 32'h5a68_0164;

    typedef struct packed {
        logic         wen;
        access_size_t size;
        logic [31:0]  addr;
        logic [31:0]  wdata;
    } data_op_t;

    logic              clk;
    logic              reset;
    logic              dreq_valid;
    logic              dreq_wen;
    access_size_t      dreq_size;
    logic [ADDR_W-1:0] dreq_addr;
    logic [DATA_W-1:0] dreq_wdata;
    logic              dreq_ready;
    logic              dresp_valid;
    logic [DATA_W-1:0] dresp_rdata;
    logic              freq_valid;
    logic [ADDR_W-1:0] freq_addr;
    logic              freq_ready;
    logic              fresp_valid;
    logic [DATA_W-1:0] fresp_instr;

    logic [7:0]  mirror [MEM_BYTES];   // byte image of the ram
    data_op_t    d_pend [$];
    logic [31:0] f_pend [$];
    data_op_t    d_op;
    logic [31:0] f_addr;
    logic [31:0] expect_val;
    logic [31:0] lfsr;
    int          cycle_count;
    int          d_gap;                // cycles since last data response
    int          f_gap;
    logic        stress_on;

    lsu_mem_top lsu_mem_top_i (
        .clk, .reset,
        .dreq_valid, .dreq_wen, .dreq_size, .dreq_addr, .dreq_wdata, .dreq_ready,
        .dresp_valid, .dresp_rdata,
        .freq_valid, .freq_addr, .freq_ready, .fresp_valid, .fresp_instr
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic access_size_t pick_size(input logic [31:0] r);
        case (r % 3)
            0:       return SIZE_B;
            1:       return SIZE_H;
            default: return SIZE_W;
        endcase
    endfunction

    function automatic int size_bytes(input access_size_t s);
        return (s == SIZE_B) ? 1 : (s == SIZE_H) ? 2 : 4;
    endfunction

    // little endian, zero above the accessed bytes, wraps at the ram size
    function automatic logic [31:0] read_mirror(input logic [31:0] addr, input int n);
        logic [31:0] v;
        logic [31:0] a;
        v = '0;
        for (int i = 0; i < n; i++) begin
            a = addr + 32'(i);
            v[8*i +: 8] = mirror[a[MEM_IDX_W+1:0]];
        end
        return v;
    endfunction

    task automatic write_mirror(input logic [31:0] addr, input logic [31:0] wdata, input int n);
        logic [31:0] a;
        for (int i = 0; i < n; i++) begin
            a = addr + 32'(i);
            mirror[a[MEM_IDX_W+1:0]] = wdata[8*i +: 8];
        end
    endtask

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_data(input logic wen, input access_size_t size,
                             input logic [31:0] addr, input logic [31:0] wdata);
        data_op_t op;
        op = '{wen, size, addr, wdata};
        dreq_valid = 1'b1;
        dreq_wen   = wen;
        dreq_size  = size;
        dreq_addr  = addr;
        dreq_wdata = wdata;
        while (!dreq_ready) @(negedge clk);
        d_pend.push_back(op);
        @(negedge clk);
        dreq_valid = 1'b0;
    endtask

    task automatic send_fetch(input logic [31:0] addr);
        freq_valid = 1'b1;
        freq_addr  = addr;
        while (!freq_ready) @(negedge clk);
        f_pend.push_back(addr);
        @(negedge clk);
        freq_valid = 1'b0;
    endtask

    task automatic rand_data_op(input int n_words);
        access_size_t size;
        logic [31:0]  addr;
        size = pick_size(rand_bits(2));
        addr = (rand_bits(8) % n_words) * 4 + rand_bits(2);
        send_data(rand_bits(1) != 0, size, addr, rand_bits(32));
    endtask

    task automatic drain();
        while (d_pend.size() != 0 || f_pend.size() != 0) @(negedge clk);
    endtask

    task automatic check_data_resp();
        if (d_pend.size() == 0) begin
            $display("data response pulse with no data request outstanding");
            abort_run();
        end else begin
            d_op = d_pend.pop_front();
            expect_val = d_op.wen ? 32'h0 : read_mirror(d_op.addr, size_bytes(d_op.size));
            assert (dresp_rdata === expect_val) else begin
                $display("[FAIL] dresp_rdata addr %08h: expected %08h actual %08h",
                         d_op.addr, expect_val, dresp_rdata);
                abort_run();
            end
            if (d_op.wen) write_mirror(d_op.addr, d_op.wdata, size_bytes(d_op.size));
        end
    endtask

    task automatic check_fetch_resp();
        if (f_pend.size() == 0) begin
            $display("fetch response pulse with no fetch request outstanding");
            abort_run();
        end else begin
            f_addr = f_pend.pop_front();
            expect_val = read_mirror({f_addr[31:1], 1'b0}, 4);
            assert (fresp_instr === expect_val) else begin
                $display("[FAIL] fresp_instr addr %08h: expected %08h actual %08h",
                         f_addr, expect_val, fresp_instr);
                abort_run();
            end
        end
    endtask

    // responses are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        cycle_count++;
        d_gap = (dresp_valid || !stress_on) ? 0 : d_gap + 1;
        f_gap = (fresp_valid || !stress_on) ? 0 : f_gap + 1;
        if (!reset && dresp_valid) check_data_resp();
        if (!reset && fresp_valid) check_fetch_resp();
        if (cycle_count > TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            abort_run();
        end
    end

    resp_low_after_reset: assert property (@(posedge clk)
        reset |=> !dresp_valid && !fresp_valid)
        else begin
            $display("response valid high after a reset cycle");
            abort_run();
        end

    dresp_one_cycle: assert property (@(posedge clk) disable iff (reset)
        dresp_valid |=> !dresp_valid)
        else begin
            $display("data response held longer than one cycle");
            abort_run();
        end

    fresp_one_cycle: assert property (@(posedge clk) disable iff (reset)
        fresp_valid |=> !fresp_valid)
        else begin
            $display("fetch response held longer than one cycle");
            abort_run();
        end

    dresp_when_idle: assert property (@(posedge clk) disable iff (reset)
        dresp_valid |-> dreq_ready)
        else begin
            $display("data response while the data port is not ready");
            abort_run();
        end

    fresp_when_idle: assert property (@(posedge clk) disable iff (reset)
        fresp_valid |-> freq_ready)
        else begin
            $display("fetch response while the fetch port is not ready");
            abort_run();
        end

    data_not_starved: assert property (@(posedge clk) disable iff (reset)
        stress_on |-> d_gap <= RR_WINDOW)
        else begin
            $display("data port got no response within the round-robin window");
            abort_run();
        end

    fetch_not_starved: assert property (@(posedge clk) disable iff (reset)
        stress_on |-> f_gap <= RR_WINDOW)
        else begin
            $display("fetch port got no response within the round-robin window");
            abort_run();
        end

    task automatic data_stress();
        repeat (N_STRESS) rand_data_op(63);   // words 0..63 only
        while (d_pend.size() != 0) @(negedge clk);
        stress_on = 1'b0;
    endtask

    task automatic fetch_stress();
        repeat (N_STRESS) send_fetch((64 + rand_bits(5) % 31) * 4 + 2 * rand_bits(1));
        while (f_pend.size() != 0) @(negedge clk);
        stress_on = 1'b0;
    endtask

    initial begin
        access_size_t size;
        logic [31:0]  base;
        logic [31:0]  off;
        logic [31:0]  wrap;
        clk         = 1'b0;
        reset       = 1'b1;
        dreq_valid  = 1'b0;
        dreq_wen    = 1'b0;
        dreq_size   = SIZE_W;
        dreq_addr   = '0;
        dreq_wdata  = '0;
        freq_valid  = 1'b0;
        freq_addr   = '0;
        lfsr        = SEED;
        cycle_count = 0;
        d_gap       = 0;
        f_gap       = 0;
        stress_on   = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (dreq_ready && freq_ready) else begin
            $display("ports did not become ready after reset");
            abort_run();
        end
        for (int i = 0; i < N_INIT; i++) send_data(1'b1, SIZE_W, 32'(i) * 4, rand_bits(32));
        for (int i = 0; i < N_INIT; i++) send_data(1'b0, SIZE_W, 32'(i) * 4, 32'h0);
        drain();
        // every size at every offset, upper address bits wrap
        for (int b = 0; b < N_LOAD_BASE; b++) begin
            base = rand_bits(6) % 63;
            wrap = rand_bits(3) * MEM_BYTES;
            for (int o = 0; o < 4; o++) begin
                for (int s = 0; s < 3; s++) begin
                    send_data(1'b0, pick_size(32'(s)), base * 4 + 32'(o) + wrap, 32'h0);
                end
            end
        end
        drain();
        for (int i = 0; i < N_STORE; i++) begin
            size = pick_size(rand_bits(2));
            base = rand_bits(6) % 63;
            off  = (size == SIZE_W) ? 1 + rand_bits(2) % 3 : rand_bits(2);
            send_data(1'b1, size, base * 4 + off, rand_bits(32));
            send_data(1'b0, SIZE_W, base * 4, 32'h0);       // both touched words
            send_data(1'b0, SIZE_W, base * 4 + 4, 32'h0);
        end
        drain();
        for (int i = 0; i < N_FETCH; i++) begin
            base = rand_bits(7) % 95;
            send_fetch(base * 4 + 32'(2 * (i % 2)) + rand_bits(1));  // bit 0 ignored
        end
        drain();
        stress_on = 1'b1;
        fork
            data_stress();
            fetch_stress();
        join
        drain();
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verilog/lsu_mem_top.sv
`timescale 1ns/100ps

module lsu_mem_top import lsu_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              dreq_valid,
    input  logic              dreq_wen,
    input  access_size_t      dreq_size,
    input  logic [ADDR_W-1:0] dreq_addr,
    input  logic [DATA_W-1:0] dreq_wdata,
    output logic              dreq_ready,
    output logic              dresp_valid,
    output logic [DATA_W-1:0] dresp_rdata,
    input  logic              freq_valid,
    input  logic [ADDR_W-1:0] freq_addr,
    output logic              freq_ready,
    output logic              fresp_valid,
    output logic [DATA_W-1:0] fresp_instr
);

    // data controller to arbiter
    logic              d_req_valid;
    logic              d_req_ready;
    logic              d_req_wen;
    logic [ADDR_W-1:0] d_req_addr;
    logic [DATA_W-1:0] d_req_wdata;
    logic              d_resp_valid;
    logic [DATA_W-1:0] d_resp_rdata;

    // fetch controller to arbiter
    logic              f_req_valid;
    logic              f_req_ready;
    logic              f_req_wen;
    logic [ADDR_W-1:0] f_req_addr;
    logic [DATA_W-1:0] f_req_wdata;
    logic              f_resp_valid;
    logic [DATA_W-1:0] f_resp_rdata;

    // arbiter to memory
    logic              mem_req_valid;
    logic              mem_req_ready;
    logic              mem_req_wen;
    logic [ADDR_W-1:0] mem_req_addr;
    logic [DATA_W-1:0] mem_req_wdata;
    logic              mem_resp_valid;
    logic [DATA_W-1:0] mem_resp_rdata;

    daccess_ctrl daccess_ctrl_i (
        .clk, .reset,
        .dreq_valid, .dreq_wen, .dreq_size, .dreq_addr, .dreq_wdata, .dreq_ready,
        .dresp_valid, .dresp_rdata,
        .m_req_valid (d_req_valid),  .m_req_wen   (d_req_wen),
        .m_req_addr  (d_req_addr),   .m_req_wdata (d_req_wdata),
        .m_req_ready (d_req_ready),
        .m_resp_valid(d_resp_valid), .m_resp_rdata(d_resp_rdata)
    );

    ifetch_ctrl ifetch_ctrl_i (
        .clk, .reset,
        .freq_valid, .freq_addr, .freq_ready, .fresp_valid, .fresp_instr,
        .m_req_valid (f_req_valid),  .m_req_wen   (f_req_wen),
        .m_req_addr  (f_req_addr),   .m_req_wdata (f_req_wdata),
        .m_req_ready (f_req_ready),
        .m_resp_valid(f_resp_valid), .m_resp_rdata(f_resp_rdata)
    );

    mem_arbiter mem_arbiter_i (
        .clk, .reset,
        .d_req_valid, .d_req_wen, .d_req_addr, .d_req_wdata, .d_req_ready,
        .d_resp_valid, .d_resp_rdata,
        .f_req_valid, .f_req_wen, .f_req_addr, .f_req_wdata, .f_req_ready,
        .f_resp_valid, .f_resp_rdata,
        .mem_req_valid, .mem_req_wen, .mem_req_addr, .mem_req_wdata, .mem_req_ready,
        .mem_resp_valid, .mem_resp_rdata
    );

    word_ram word_ram_i (
        .clk, .reset,
        .mem_req_valid, .mem_req_wen, .mem_req_addr, .mem_req_wdata, .mem_req_ready,
        .mem_resp_valid, .mem_resp_rdata
    );

endmodule

//--- verilog/ifetch_ctrl.sv
`timescale 1ns/100ps

module ifetch_ctrl import lsu_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              freq_valid,
    input  logic [ADDR_W-1:0] freq_addr,
    output logic              freq_ready,
    output logic              fresp_valid,
    output logic [DATA_W-1:0] fresp_instr,
    output logic              m_req_valid,
    output logic              m_req_wen,
    output logic [ADDR_W-1:0] m_req_addr,
    output logic [DATA_W-1:0] m_req_wdata,
    input  logic              m_req_ready,
    input  logic              m_resp_valid,
    input  logic [DATA_W-1:0] m_resp_rdata
);

    typedef enum logic [2:0] {
        IDLE,
        REQ_LO,
        RESP_LO,
        REQ_HI,
        RESP_HI
    } state_t;

    state_t              state;
    logic [ADDR_W-1:1]   pc;         // halfword address, bit 0 dropped
    logic [ADDR_W-1:0]   word_addr;
    logic [DATA_W/2-1:0] low_half;   // upper half of first word at offset 2

    assign word_addr   = {pc[ADDR_W-1:2], 2'b00};
    assign freq_ready  = state == IDLE;
    assign m_req_valid = state == REQ_LO || state == REQ_HI;
    assign m_req_wen   = 1'b0;       // read only
    assign m_req_wdata = '0;
    assign m_req_addr  = (state == REQ_HI) ? word_addr + ADDR_W'(4) : word_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            fresp_valid <= 1'b0;
        end else begin
            fresp_valid <= 1'b0;
            case (state)
                IDLE:    if (freq_valid) state <= REQ_LO;
                REQ_LO:  if (m_req_ready) state <= RESP_LO;
                RESP_LO: begin
                    if (m_resp_valid) begin
                        if (pc[1]) begin
                            state <= REQ_HI;       // straddles two words
                        end else begin
                            state       <= IDLE;
                            fresp_valid <= 1'b1;
                        end
                    end
                end
                REQ_HI:  if (m_req_ready) state <= RESP_HI;
                RESP_HI: begin
                    if (m_resp_valid) begin
                        state       <= IDLE;
                        fresp_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && freq_valid) begin
            pc <= freq_addr[ADDR_W-1:1];
        end
        if (state == RESP_LO && m_resp_valid) begin
            low_half    <= m_resp_rdata[DATA_W-1:DATA_W/2];
            fresp_instr <= m_resp_rdata;
        end
        if (state == RESP_HI && m_resp_valid) begin
            fresp_instr <= {m_resp_rdata[DATA_W/2-1:0], low_half};
        end
    end

endmodule

//--- verilog/daccess_ctrl.sv
`timescale 1ns/100ps

module daccess_ctrl import lsu_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              dreq_valid,
    input  logic              dreq_wen,
    input  access_size_t      dreq_size,
    input  logic [ADDR_W-1:0] dreq_addr,
    input  logic [DATA_W-1:0] dreq_wdata,
    output logic              dreq_ready,
    output logic              dresp_valid,
    output logic [DATA_W-1:0] dresp_rdata,
    output logic              m_req_valid,
    output logic              m_req_wen,
    output logic [ADDR_W-1:0] m_req_addr,
    output logic [DATA_W-1:0] m_req_wdata,
    input  logic              m_req_ready,
    input  logic              m_resp_valid,
    input  logic [DATA_W-1:0] m_resp_rdata
);

    typedef enum logic [3:0] {
        IDLE,
        RD_REQ,
        RD_RESP,
        RD_REQ2,
        RD_RESP2,
        MERGE,
        WR_REQ,
        WR_RESP,
        WR_REQ2,
        WR_RESP2
    } state_t;

    state_t state;

    // latched request
    logic              req_wen;
    access_size_t      req_size;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;

    logic [DATA_W-1:0] rd_lo;   // aligned word
    logic [DATA_W-1:0] rd_hi;   // following word when crossing
    logic [DATA_W-1:0] wr_lo;
    logic [DATA_W-1:0] wr_hi;

    logic [1:0]          offset;
    logic [4:0]          shamt;
    logic [ADDR_W-1:0]   addr_lo;
    logic [ADDR_W-1:0]   addr_hi;
    logic                crosses;
    logic                full_word;
    logic [DATA_W-1:0]   size_mask;
    logic [2*DATA_W-1:0] byte_mask;
    logic [2*DATA_W-1:0] old_pair;
    logic [2*DATA_W-1:0] new_pair;
    logic [2*DATA_W-1:0] merged;
    logic [2*DATA_W-1:0] load_pair;
    logic [DATA_W-1:0]   load_data;

    assign offset  = req_addr[1:0];
    assign shamt   = {offset, 3'b000};
    assign addr_lo = {req_addr[ADDR_W-1:2], 2'b00};
    assign addr_hi = addr_lo + ADDR_W'(4);
    assign crosses = (req_size == SIZE_W && offset != 2'd0) ||
                     (req_size == SIZE_H && offset == 2'd3);

    // aligned word store needs no read phase
    assign full_word = dreq_wen && dreq_size == SIZE_W && dreq_addr[1:0] == 2'b00;

    always_comb begin
        case (req_size)
            SIZE_B:  size_mask = DATA_W'(32'h0000_00ff);
            SIZE_H:  size_mask = DATA_W'(32'h0000_ffff);
            default: size_mask = '1;
        endcase
    end

    // both words viewed as one little-endian byte string
    assign old_pair  = {rd_hi, rd_lo};
    assign byte_mask = {{DATA_W{1'b0}}, size_mask} << shamt;
    assign new_pair  = {{DATA_W{1'b0}}, req_wdata} << shamt;
    assign merged    = (old_pair & ~byte_mask) | (new_pair & byte_mask);
    assign load_pair = old_pair >> shamt;
    assign load_data = load_pair[DATA_W-1:0] & size_mask;  // zero fill above size

    assign dreq_ready  = state == IDLE;
    assign m_req_valid = state inside {RD_REQ, RD_REQ2, WR_REQ, WR_REQ2};
    assign m_req_wen   = state inside {WR_REQ, WR_REQ2};
    assign m_req_addr  = (state == RD_REQ2 || state == WR_REQ2) ? addr_hi : addr_lo;
    assign m_req_wdata = (state == WR_REQ2) ? wr_hi : wr_lo;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            dresp_valid <= 1'b0;
        end else begin
            dresp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (dreq_valid) begin
                        state <= full_word ? WR_REQ : RD_REQ;
                    end
                end
                RD_REQ: begin
                    if (m_req_ready) begin
                        state <= RD_RESP;
                    end
                end
                RD_RESP: begin
                    if (m_resp_valid) begin
                        state <= crosses ? RD_REQ2 : MERGE;
                    end
                end
                RD_REQ2: begin
                    if (m_req_ready) begin
                        state <= RD_RESP2;
                    end
                end
                RD_RESP2: begin
                    if (m_resp_valid) begin
                        state <= MERGE;
                    end
                end
                MERGE: begin
                    if (req_wen) begin
                        state <= WR_REQ;
                    end else begin
                        state       <= IDLE;
                        dresp_valid <= 1'b1;   // load result ready
                    end
                end
                WR_REQ: begin
                    if (m_req_ready) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (m_resp_valid) begin
                        if (crosses) begin
                            state <= WR_REQ2;
                        end else begin
                            state       <= IDLE;
                            dresp_valid <= 1'b1;
                        end
                    end
                end
                WR_REQ2: begin
                    if (m_req_ready) begin
                        state <= WR_RESP2;
                    end
                end
                WR_RESP2: begin
                    if (m_resp_valid) begin
                        state       <= IDLE;
                        dresp_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && dreq_valid) begin
            req_wen     <= dreq_wen;
            req_size    <= dreq_size;
            req_addr    <= dreq_addr;
            req_wdata   <= dreq_wdata;
            wr_lo       <= dreq_wdata;  // used as is by aligned word store
            dresp_rdata <= '0;          // stores answer with zero
        end
        if (state == RD_RESP && m_resp_valid) begin
            rd_lo <= m_resp_rdata;
        end
        if (state == RD_RESP2 && m_resp_valid) begin
            rd_hi <= m_resp_rdata;
        end
        if (state == MERGE) begin
            wr_lo <= merged[DATA_W-1:0];
            wr_hi <= merged[2*DATA_W-1:DATA_W];
            if (!req_wen) begin
                dresp_rdata <= load_data;
            end
        end
    end

    // arbiter routes responses only while this side waits for one
    assert property (@(posedge clk) disable iff (reset)
        m_resp_valid |-> state inside {RD_RESP, RD_RESP2, WR_RESP, WR_RESP2});

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter import lsu_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              d_req_valid,
    input  logic              d_req_wen,
    input  logic [ADDR_W-1:0] d_req_addr,
    input  logic [DATA_W-1:0] d_req_wdata,
    output logic              d_req_ready,
    output logic              d_resp_valid,
    output logic [DATA_W-1:0] d_resp_rdata,
    input  logic              f_req_valid,
    input  logic              f_req_wen,
    input  logic [ADDR_W-1:0] f_req_addr,
    input  logic [DATA_W-1:0] f_req_wdata,
    output logic              f_req_ready,
    output logic              f_resp_valid,
    output logic [DATA_W-1:0] f_resp_rdata,
    output logic              mem_req_valid,
    output logic              mem_req_wen,
    output logic [ADDR_W-1:0] mem_req_addr,
    output logic [DATA_W-1:0] mem_req_wdata,
    input  logic              mem_req_ready,
    input  logic              mem_resp_valid,
    input  logic [DATA_W-1:0] mem_resp_rdata
);

    logic last_f;       // fetch port won the last grant
    logic outstanding;  // one access in flight
    logic owner_f;      // response belongs to fetch port
    logic grant_d;
    logic grant_f;
    logic accept;

    // when both ask, the side that did not win last time goes first
    assign grant_f = !outstanding && f_req_valid && (!d_req_valid || !last_f);
    assign grant_d = !outstanding && d_req_valid && !grant_f;

    assign mem_req_valid = grant_d || grant_f;
    assign mem_req_wen   = grant_f ? f_req_wen   : d_req_wen;
    assign mem_req_addr  = grant_f ? f_req_addr  : d_req_addr;
    assign mem_req_wdata = grant_f ? f_req_wdata : d_req_wdata;
    assign accept        = mem_req_valid && mem_req_ready;

    assign d_req_ready = grant_d && mem_req_ready;  // loser sees ready low
    assign f_req_ready = grant_f && mem_req_ready;

    assign d_resp_valid = mem_resp_valid && !owner_f;
    assign f_resp_valid = mem_resp_valid && owner_f;
    assign d_resp_rdata = mem_resp_rdata;
    assign f_resp_rdata = mem_resp_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_f      <= 1'b0;
            outstanding <= 1'b0;
            owner_f     <= 1'b0;
        end else if (accept) begin
            last_f      <= grant_f;
            outstanding <= 1'b1;
            owner_f     <= grant_f;
        end else if (mem_resp_valid) begin
            outstanding <= 1'b0;
        end
    end

    // memory must not answer anything it was not given
    assert property (@(posedge clk) disable iff (reset)
        mem_resp_valid |-> outstanding);

endmodule

//--- verilog/word_ram.sv
`timescale 1ns/100ps

module word_ram import lsu_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_req_valid,
    input  logic              mem_req_wen,
    input  logic [ADDR_W-1:0] mem_req_addr,
    input  logic [DATA_W-1:0] mem_req_wdata,
    output logic              mem_req_ready,
    output logic              mem_resp_valid,
    output logic [DATA_W-1:0] mem_resp_rdata
);

    logic [DATA_W/8-1:0][7:0] mem [MEM_WORDS];    // words kept as byte lanes
    logic [MEM_IDX_W-1:0]     word_idx;
    logic                     accept;

    assign mem_req_ready = 1'b1;                    // single-cycle array, never stalls
    assign accept        = mem_req_valid && mem_req_ready;
    assign word_idx      = mem_req_addr[MEM_IDX_W+1:2];  // upper bits wrap

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_resp_valid <= 1'b0;
        end else begin
            mem_resp_valid <= accept;
        end
    end

    // read returns the word as it was before any write in the same access
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_resp_rdata <= mem[word_idx];
            if (mem_req_wen) begin
                for (int b = 0; b < DATA_W / 8; b++) begin
                    mem[word_idx][b] <= mem_req_wdata[8*b +: 8];
                end
            end
        end
    end

    // both controllers must hand over word-aligned addresses
    assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> mem_req_addr[1:0] == 2'b00);

endmodule

//--- verilog/lsu_mem_pkg.sv
package lsu_mem_pkg;

    localparam int ADDR_W    = 32;                  // byte address width
    localparam int DATA_W    = 32;                  // one memory word
    localparam int MEM_WORDS = 256;                 // 1 KB of storage
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);   // word index bits

    // width of a data port access
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,  // byte
        SIZE_H = 2'd1,  // halfword
        SIZE_W = 2'd2   // word
    } access_size_t;

endpackage
